//--- logic/bk_bus_pkg.sv
`default_nettype none

package bk_bus_pkg;

	// Bus data and address words
	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;

	// Byte select, bit 1 is the high byte
	typedef logic [1:0] bsel_t;

	// I/O register addresses
	localparam addr_t SYSREG_ADDR = 16'o177716;
	localparam addr_t PORT_ADDR   = 16'o177714;

	// Joystick buttons and mouse motion delta
	typedef logic [7:0] joy_t;
	typedef logic [8:0] motion_t;

	typedef enum logic {IDLE, ACK} ack_state_t;

endpackage

`default_nettype wire

//--- logic/bk_audio_pkg.sv
`default_nettype none

package bk_audio_pkg;

	// DAC input word
	typedef logic [9:0] sample_t;

	// PSG channel level
	typedef logic [7:0] chan_t;

	// Speaker level from the system register
	typedef logic [2:0] spk_t;

	// Speaker weight with the PSG running and alone
	localparam int SPK_MIX_SHIFT  = 5;
	localparam int SPK_SOLO_SHIFT = 7;

endpackage

`default_nettype wire

//--- logic/bk_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// One register access, decoder to register block
interface bk_reg_if;

	logic              access;
	logic              we;
	bk_bus_pkg::bsel_t sel;
	bk_bus_pkg::word_t wdata;
	bk_bus_pkg::word_t rdata;

	modport decoder (
		output access,
		output we,
		output sel,
		output wdata,
		input  rdata
	);

	modport target (
		input  access,
		input  we,
		input  sel,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- logic/bk_sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

// First order sigma-delta, one bit out
module bk_sigma_delta_dac #(
	parameter int DAC_MSB = 9
) (
	input  wire               clk_sys,
	input  wire               rst_i,
	input  wire [DAC_MSB:0]   sample_i,
	output logic              dac_o
);

	// Top bit is the carry, the rest is the running remainder
	logic [DAC_MSB+1:0] acc;

	always_ff @(posedge clk_sys) begin
		if (rst_i)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_MSB:0]} + {1'b0, sample_i};
	end

	assign dac_o = acc[DAC_MSB+1];

endmodule

`default_nettype wire

//--- logic/bk_audio_out.sv
`timescale 1ns/1ps
`default_nettype none

module bk_audio_out (
	input  wire                       clk_sys,
	input  wire                       rst_i,
	input  wire bk_audio_pkg::spk_t   spk_i,
	input  wire bk_audio_pkg::chan_t  psg_a_i,
	input  wire bk_audio_pkg::chan_t  psg_b_i,
	input  wire bk_audio_pkg::chan_t  psg_c_i,
	input  wire [5:0]                 psg_active_i,
	output logic                      audio_l_o,
	output logic                      audio_r_o
);

	bk_audio_pkg::sample_t spk_mix;
	bk_audio_pkg::sample_t spk_solo;
	bk_audio_pkg::sample_t mix_l;
	bk_audio_pkg::sample_t mix_r;

	assign spk_mix  = bk_audio_pkg::sample_t'(spk_i) << bk_audio_pkg::SPK_MIX_SHIFT;
	assign spk_solo = bk_audio_pkg::sample_t'(spk_i) << bk_audio_pkg::SPK_SOLO_SHIFT;

	// Channel B in the middle, A left and C right at double weight
	assign mix_l = (|psg_active_i) ?
		bk_audio_pkg::sample_t'({psg_a_i, 1'b0}) + bk_audio_pkg::sample_t'(psg_b_i) + spk_mix :
		spk_solo;
	assign mix_r = (|psg_active_i) ?
		bk_audio_pkg::sample_t'({psg_c_i, 1'b0}) + bk_audio_pkg::sample_t'(psg_b_i) + spk_mix :
		spk_solo;

	bk_sigma_delta_dac #(.DAC_MSB($bits(bk_audio_pkg::sample_t) - 1)) dac_l (
		.clk_sys  (clk_sys),
		.rst_i    (rst_i),
		.sample_i (mix_l),
		.dac_o    (audio_l_o)
	);

	bk_sigma_delta_dac #(.DAC_MSB($bits(bk_audio_pkg::sample_t) - 1)) dac_r (
		.clk_sys  (clk_sys),
		.rst_i    (rst_i),
		.sample_i (mix_r),
		.dac_o    (audio_r_o)
	);

endmodule

`default_nettype wire

//--- logic/bk_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bk_bus_decoder (
	input  wire                       clk_sys,
	input  wire                       rst_i,
	input  wire                       wb_cyc_i,
	input  wire                       wb_stb_i,
	input  wire                       wb_we_i,
	input  wire bk_bus_pkg::addr_t    wb_adr_i,
	input  wire bk_bus_pkg::bsel_t    wb_sel_i,
	input  wire bk_bus_pkg::word_t    wb_dat_i,
	output bk_bus_pkg::word_t         wb_dat_o,
	output logic                      wb_ack_o,
	bk_reg_if.decoder                 sys_bus,
	bk_reg_if.decoder                 port_bus
);

	bk_bus_pkg::ack_state_t state_q;
	logic                   req;
	logic                   sys_hit;
	logic                   port_hit;

	// Word match, byte address bit 0 ignored
	assign sys_hit  = (wb_adr_i[15:1] == bk_bus_pkg::SYSREG_ADDR[15:1]);
	assign port_hit = (wb_adr_i[15:1] == bk_bus_pkg::PORT_ADDR[15:1]);

	assign req = wb_cyc_i && wb_stb_i && (state_q == bk_bus_pkg::IDLE);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state_q  <= bk_bus_pkg::IDLE;
			wb_dat_o <= '0;
		end else begin
			case (state_q)
				bk_bus_pkg::IDLE: if (req) state_q <= bk_bus_pkg::ACK;
				default:          state_q <= bk_bus_pkg::IDLE;
			endcase
			// Read data sampled before the access edge, zero outside ack
			if (req && sys_hit)
				wb_dat_o <= sys_bus.rdata;
			else if (req && port_hit)
				wb_dat_o <= port_bus.rdata;
			else
				wb_dat_o <= '0;
		end
	end

	assign wb_ack_o = (state_q == bk_bus_pkg::ACK);

	//////////////////////////////////////////////////////////////////////
	// Access pulses, one per register block
	//////////////////////////////////////////////////////////////////////
	assign sys_bus.access  = wb_ack_o && sys_hit;
	assign sys_bus.we      = wb_we_i;
	assign sys_bus.sel     = wb_sel_i;
	assign sys_bus.wdata   = wb_dat_i;

	assign port_bus.access = wb_ack_o && port_hit;
	assign port_bus.we     = wb_we_i;
	assign port_bus.sel    = wb_sel_i;
	assign port_bus.wdata  = wb_dat_i;

endmodule

`default_nettype wire

//--- logic/bk_sysreg.sv
`timescale 1ns/1ps
`default_nettype none

module bk_sysreg (
	input  wire                  clk_sys,
	input  wire                  rst_i,
	bk_reg_if.target             bus,
	input  wire [7:0]            start_addr_i,
	input  wire                  key_down_i,
	input  wire                  key_stop_i,
	input  wire                  model_bk0010_i,
	output bk_audio_pkg::spk_t   spk_o,
	output logic                 irq_stop_o
);

	logic super_flg;
	logic stop_block;
	logic wr;

	assign wr = bus.access && bus.we;

	// Readback: start address, fixed one, key up, supervisor flag
	assign bus.rdata = {start_addr_i, 1'b1, ~key_down_i, 3'b000, super_flg, 2'b00};

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			super_flg  <= 1'b0;
			stop_block <= 1'b0;
			spk_o      <= '0;
		end else begin
			// Any access updates the flag, a write sets it
			if (bus.access)
				super_flg <= bus.we;
			// Bit 11 set means the high byte is not a control write
			if (wr && bus.sel[1] && !bus.wdata[11])
				stop_block <= bus.wdata[12];
			if (wr && bus.sel[0] && (!bus.sel[1] || !bus.wdata[11])) begin
				// BK0010 has no third speaker bit
				spk_o <= {bus.wdata[6], bus.wdata[5], bus.wdata[2] & ~model_bk0010_i};
			end
		end
	end

	assign irq_stop_o = key_stop_i && !stop_block;

endmodule

`default_nettype wire

//--- logic/bk_port_reg.sv
`timescale 1ns/1ps
`default_nettype none

module bk_port_reg (
	input  wire                       clk_sys,
	input  wire                       rst_i,
	bk_reg_if.target                  bus,
	input  wire bk_bus_pkg::joy_t     joy0_i,
	input  wire bk_bus_pkg::joy_t     joy1_i,
	input  wire                       mouse_strobe_i,
	input  wire bk_bus_pkg::motion_t  mouse_dx_i,
	input  wire bk_bus_pkg::motion_t  mouse_dy_i,
	input  wire [1:0]                 mouse_btn_i
);

	bk_bus_pkg::joy_t joy_q;
	logic [1:0]       btn_q;
	logic [3:0]       dir_q;
	logic             mouse_mode;
	logic             mouse_en;
	logic             ctrl_wr;
	logic [6:0]       mouse_state;

	assign ctrl_wr = bus.access && bus.we && bus.sel[0];

	// Bit 6 right, bit 5 left, bits 3..0 left/down/right/up
	assign mouse_state = {btn_q[0], btn_q[1], 1'b0, dir_q};

	assign bus.rdata = mouse_mode ? {9'b0, mouse_state} : {8'b0, joy_q};

	// Buttons just follow their inputs
	always_ff @(posedge clk_sys) begin
		joy_q <= joy0_i | joy1_i;
		btn_q <= mouse_btn_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Mode select and direction tracking
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			mouse_mode <= 1'b0;
			mouse_en   <= 1'b0;
			dir_q      <= '0;
		end else begin
			if (|(joy0_i | joy1_i))
				mouse_mode <= 1'b0;
			// Strobe wins over the joystick
			if (mouse_strobe_i)
				mouse_mode <= 1'b1;

			if (ctrl_wr) begin
				mouse_en <= bus.wdata[3];
				if (!bus.wdata[3])
					dir_q <= '0;
			end else if (mouse_strobe_i && mouse_en) begin
				// Vertical axis, up or down
				if (!dir_q[0] && !dir_q[2]) begin
					if ($signed(mouse_dy_i) >= 9'sd4)
						dir_q[0] <= 1'b1;
					if ($signed(mouse_dy_i) <= -9'sd4)
						dir_q[2] <= 1'b1;
				end
				// Horizontal axis, right or left
				if (!dir_q[1] && !dir_q[3]) begin
					if ($signed(mouse_dx_i) >= 9'sd4)
						dir_q[1] <= 1'b1;
					if ($signed(mouse_dx_i) <= -9'sd4)
						dir_q[3] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/bk_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module bk_io_top (
	input  wire                       clk_sys,
	input  wire                       rst_i,
	input  wire                       wb_cyc_i,
	input  wire                       wb_stb_i,
	input  wire                       wb_we_i,
	input  wire bk_bus_pkg::addr_t    wb_adr_i,
	input  wire bk_bus_pkg::bsel_t    wb_sel_i,
	input  wire bk_bus_pkg::word_t    wb_dat_i,
	output bk_bus_pkg::word_t         wb_dat_o,
	output logic                      wb_ack_o,
	input  wire [7:0]                 start_addr_i,
	input  wire                       key_down_i,
	input  wire                       key_stop_i,
	input  wire                       model_bk0010_i,
	input  wire bk_bus_pkg::joy_t     joy0_i,
	input  wire bk_bus_pkg::joy_t     joy1_i,
	input  wire                       mouse_strobe_i,
	input  wire bk_bus_pkg::motion_t  mouse_dx_i,
	input  wire bk_bus_pkg::motion_t  mouse_dy_i,
	input  wire [1:0]                 mouse_btn_i,
	input  wire bk_audio_pkg::chan_t  psg_a_i,
	input  wire bk_audio_pkg::chan_t  psg_b_i,
	input  wire bk_audio_pkg::chan_t  psg_c_i,
	input  wire [5:0]                 psg_active_i,
	output logic                      irq_stop_o,
	output logic                      audio_l_o,
	output logic                      audio_r_o
);

	bk_reg_if sys_bus ();
	bk_reg_if port_bus ();

	bk_audio_pkg::spk_t spk;

	bk_bus_decoder u_decoder (
		.clk_sys (clk_sys), .rst_i (rst_i),
		.wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
		.wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i), .wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
		.sys_bus (sys_bus.decoder), .port_bus (port_bus.decoder)
	);

	bk_sysreg u_sysreg (
		.clk_sys (clk_sys), .rst_i (rst_i), .bus (sys_bus.target),
		.start_addr_i (start_addr_i), .key_down_i (key_down_i),
		.key_stop_i (key_stop_i), .model_bk0010_i (model_bk0010_i),
		.spk_o (spk), .irq_stop_o (irq_stop_o)
	);

	bk_port_reg u_port (
		.clk_sys (clk_sys), .rst_i (rst_i), .bus (port_bus.target),
		.joy0_i (joy0_i), .joy1_i (joy1_i), .mouse_strobe_i (mouse_strobe_i),
		.mouse_dx_i (mouse_dx_i), .mouse_dy_i (mouse_dy_i), .mouse_btn_i (mouse_btn_i)
	);

	bk_audio_out u_audio (
		.clk_sys (clk_sys), .rst_i (rst_i), .spk_i (spk),
		.psg_a_i (psg_a_i), .psg_b_i (psg_b_i), .psg_c_i (psg_c_i),
		.psg_active_i (psg_active_i), .audio_l_o (audio_l_o), .audio_r_o (audio_r_o)
	);

endmodule

`default_nettype wire

//--- tb/bk_io_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bk_io_sva (
	input wire clk_sys,
	input wire rst_i,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_ack_o,
	input wire key_stop_i,
	input wire irq_stop_o
);

	// Ack only answers an open strobe
	ack_needs_stb: assert property (@(posedge clk_sys) disable iff (rst_i)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o high without cyc and stb");

	// Single cycle ack
	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (rst_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o high for two cycles in a row");

	// STOP interrupt needs the key itself
	stop_needs_key: assert property (@(posedge clk_sys) disable iff (rst_i)
		!key_stop_i |-> !irq_stop_o)
		else $error("irq_stop_o high while key_stop_i low");

endmodule

bind bk_io_top bk_io_sva u_sva (
	.clk_sys    (clk_sys),
	.rst_i      (rst_i),
	.wb_cyc_i   (wb_cyc_i),
	.wb_stb_i   (wb_stb_i),
	.wb_ack_o   (wb_ack_o),
	.key_stop_i (key_stop_i),
	.irq_stop_o (irq_stop_o)
);

`default_nettype wire

//--- tb/bk_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bk_io_tb;

	logic                  clk_sys = 1'b0;
	logic                  rst_i;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	bk_bus_pkg::addr_t     wb_adr_i;
	bk_bus_pkg::bsel_t     wb_sel_i;
	bk_bus_pkg::word_t     wb_dat_i;
	bk_bus_pkg::word_t     wb_dat_o;
	logic                  wb_ack_o;
	logic [7:0]            start_addr_i;
	logic                  key_down_i;
	logic                  key_stop_i;
	logic                  model_bk0010_i;
	bk_bus_pkg::joy_t      joy0_i;
	bk_bus_pkg::joy_t      joy1_i;
	logic                  mouse_strobe_i;
	bk_bus_pkg::motion_t   mouse_dx_i;
	bk_bus_pkg::motion_t   mouse_dy_i;
	logic [1:0]            mouse_btn_i;
	bk_audio_pkg::chan_t   psg_a_i;
	bk_audio_pkg::chan_t   psg_b_i;
	bk_audio_pkg::chan_t   psg_c_i;
	logic [5:0]            psg_active_i;
	logic                  irq_stop_o;
	logic                  audio_l_o;
	logic                  audio_r_o;

	// Stimulus lines as read from the file
	string                 op_q[$];
	bk_bus_pkg::word_t     arg0_q[$];
	bk_bus_pkg::word_t     arg1_q[$];
	bk_bus_pkg::word_t     arg2_q[$];
	bk_bus_pkg::word_t     exp_q[$];
	int                    limit_cycles = 0;
	int                    cycle_cnt = 0;
	bit                    verdict_done = 1'b0;

	bk_io_top DUT (.*);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
			$display("Run did not finish within %0d cycles", limit_cycles);
			fail_stop();
		end
	end

	final begin
		if (!verdict_done)
			$display("Done: errors found");
	end

	task automatic fail_stop();
		verdict_done = 1'b1;
		$display("Done: errors found");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_word(string name, bk_bus_pkg::word_t got, bk_bus_pkg::word_t expected);
		if (got !== expected) begin
			$display("ERROR: %s got %h expected %h", name, got, expected);
			fail_stop();
		end
	endtask

	task automatic check_bit(string name, logic got, logic expected);
		if (got !== expected) begin
			$display("ERROR: %s got %h expected %h", name, got, expected);
			fail_stop();
		end
	endtask

	task automatic check_count(string name, int got, int expected);
		if (got < expected - 1 || got > expected + 1) begin
			$display("ERROR: %s ones count got %h expected %h", name, got, expected);
			fail_stop();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus and input drivers
	//////////////////////////////////////////////////////////////////////
	task automatic bus_access(bit we, bk_bus_pkg::addr_t adr, bk_bus_pkg::bsel_t sel,
			bk_bus_pkg::word_t dat, output bk_bus_pkg::word_t rdat);
		int waited;
		waited = 0;
		@(posedge clk_sys);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_sel_i <= sel;
		wb_dat_i <= dat;
		@(negedge clk_sys);
		while (!wb_ack_o) begin
			waited++;
			if (waited > 8) begin
				$display("Missing acknowledge for the access to address %h", adr);
				fail_stop();
			end
			@(negedge clk_sys);
		end
		rdat = wb_dat_o;
		// Master drops the strobe at the edge that ends the ack cycle
		@(posedge clk_sys);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic mouse_move(bk_bus_pkg::motion_t dx, bk_bus_pkg::motion_t dy, logic [1:0] btn);
		@(posedge clk_sys);
		mouse_strobe_i <= 1'b1;
		mouse_dx_i     <= dx;
		mouse_dy_i     <= dy;
		mouse_btn_i    <= btn;
		@(posedge clk_sys);
		mouse_strobe_i <= 1'b0;
	endtask

	task automatic audio_check(bk_bus_pkg::word_t spk_data, logic [5:0] active, logic model,
			bk_audio_pkg::spk_t spk);
		bk_audio_pkg::chan_t a;
		bk_audio_pkg::chan_t b;
		bk_audio_pkg::chan_t c;
		bk_bus_pkg::word_t   rd;
		int                  exp_l;
		int                  exp_r;
		int                  ones_l;
		int                  ones_r;
		a = bk_audio_pkg::chan_t'($urandom());
		b = bk_audio_pkg::chan_t'($urandom());
		c = bk_audio_pkg::chan_t'($urandom());
		@(posedge clk_sys);
		psg_a_i        <= a;
		psg_b_i        <= b;
		psg_c_i        <= c;
		psg_active_i   <= active;
		model_bk0010_i <= model;
		bus_access(1'b1, bk_bus_pkg::SYSREG_ADDR, 2'b01, spk_data, rd);
		// Speaker weight 32 next to the PSG, 128 alone
		if (|active) begin
			exp_l = 2 * int'(a) + int'(b) + int'(spk) * 32;
			exp_r = 2 * int'(c) + int'(b) + int'(spk) * 32;
		end else begin
			exp_l = int'(spk) * 128;
			exp_r = exp_l;
		end
		ones_l = 0;
		ones_r = 0;
		@(posedge clk_sys);
		repeat (1024) begin
			@(negedge clk_sys);
			if (audio_l_o)
				ones_l++;
			if (audio_r_o)
				ones_r++;
		end
		check_count("audio_l_o", ones_l, exp_l);
		check_count("audio_r_o", ones_r, exp_r);
	endtask

	initial begin
		int                fd;
		int                n;
		string             line;
		string             op;
		bk_bus_pkg::word_t a0;
		bk_bus_pkg::word_t a1;
		bk_bus_pkg::word_t a2;
		bk_bus_pkg::word_t ev;
		bk_bus_pkg::word_t rd;
		void'($urandom(94112));
		rst_i          <= 1'b1;
		wb_cyc_i       <= 1'b0;
		wb_stb_i       <= 1'b0;
		wb_we_i        <= 1'b0;
		wb_adr_i       <= '0;
		wb_sel_i       <= '0;
		wb_dat_i       <= '0;
		start_addr_i   <= '0;
		key_down_i     <= 1'b0;
		// STOP key held through reset to expose the block state
		key_stop_i     <= 1'b1;
		model_bk0010_i <= 1'b0;
		joy0_i         <= '0;
		joy1_i         <= '0;
		mouse_strobe_i <= 1'b0;
		mouse_dx_i     <= '0;
		mouse_dy_i     <= '0;
		mouse_btn_i    <= '0;
		psg_a_i        <= '0;
		psg_b_i        <= '0;
		psg_c_i        <= '0;
		psg_active_i   <= '0;

		fd = $fopen("tb/bk_io_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file tb/bk_io_stim.txt");
			fail_stop();
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %h %h", op, a0, a1, a2, ev);
				if (n == 5) begin
					op_q.push_back(op);
					arg0_q.push_back(a0);
					arg1_q.push_back(a1);
					arg2_q.push_back(a2);
					exp_q.push_back(ev);
				end
			end
		end
		$fclose(fd);
		limit_cycles = 200 + op_q.size() * 2100;

		repeat (16) @(posedge clk_sys);
		rst_i <= 1'b0;
		@(negedge clk_sys);
		check_bit("wb_ack_o", wb_ack_o, 1'b0);
		check_word("wb_dat_o", wb_dat_o, 16'h0000);
		check_bit("irq_stop_o", irq_stop_o, 1'b1);

		foreach (op_q[i]) begin
			case (op_q[i])
				"write": bus_access(1'b1, arg0_q[i], arg1_q[i][1:0], arg2_q[i], rd);
				"read": begin
					@(posedge clk_sys);
					start_addr_i <= arg2_q[i][7:0];
					key_down_i   <= arg2_q[i][8];
					bus_access(1'b0, arg0_q[i], arg1_q[i][1:0], 16'h0000, rd);
					check_word("wb_dat_o", rd, exp_q[i]);
				end
				"joy": begin
					@(posedge clk_sys);
					joy0_i <= arg0_q[i][7:0];
					joy1_i <= arg1_q[i][7:0];
					@(posedge clk_sys);
					bus_access(1'b0, bk_bus_pkg::PORT_ADDR, 2'b11, 16'h0000, rd);
					check_word("wb_dat_o", rd, exp_q[i]);
				end
				"mouse": begin
					mouse_move(arg0_q[i][8:0], arg1_q[i][8:0], arg2_q[i][1:0]);
					bus_access(1'b0, bk_bus_pkg::PORT_ADDR, 2'b11, 16'h0000, rd);
					check_word("wb_dat_o", rd, exp_q[i]);
				end
				"stop": begin
					@(posedge clk_sys);
					key_stop_i <= arg0_q[i][0];
					bus_access(1'b1, bk_bus_pkg::SYSREG_ADDR, 2'b10, arg1_q[i], rd);
					@(negedge clk_sys);
					check_bit("irq_stop_o", irq_stop_o, exp_q[i][0]);
				end
				"audio": audio_check(arg0_q[i], arg1_q[i][5:0], arg2_q[i][0], exp_q[i][2:0]);
				default: begin
					$display("Unknown operation %s in the stimulus file", op_q[i]);
					fail_stop();
				end
			endcase
		end

		verdict_done = 1'b1;
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/bk_io_stim.txt
# op arg0 arg1 arg2 expected, all hex
# read adr sel {key_down,start} rdata | write adr sel data - | joy j0 j1 - rdata | mouse dx dy btn rdata | stop key hi_data - irq | audio data active model spk
read  ffce 3 0c0  c0c0
write ffce 1 0000 0000
read  ffce 3 1a5  a584
read  ffce 3 1a5  a580
read  ffd0 3 000  0000
stop  1 0000 0 1
stop  1 1000 0 0
stop  1 1800 0 0
stop  1 0800 0 0
stop  1 0000 0 1
stop  0 1000 0 0
stop  0 0000 0 0
joy   15 22 0 0037
joy   00 00 0 0000
mouse 004 000 1 0040
write ffcc 1 0008 0000
mouse 004 000 2 0022
mouse 1fc 004 0 0003
mouse 1fc 1fc 3 0063
write ffcc 1 0000 0000
read  ffcc 3 1a5  0060
write ffcc 1 0008 0000
mouse 003 1fd 0 0000
mouse 1fc 1fc 0 000c
mouse 004 004 0 000c
joy   01 00 0 0001
audio 0064 3f 0 7
audio 0064 00 0 7
audio 0064 00 1 6
audio 0040 01 1 4
audio 0020 00 0 2
audio 0000 00 0 0

//--- verilog.f
logic/bk_bus_pkg.sv
logic/bk_audio_pkg.sv
logic/bk_reg_if.sv
logic/bk_sigma_delta_dac.sv
logic/bk_audio_out.sv
logic/bk_bus_decoder.sv
logic/bk_sysreg.sv
logic/bk_port_reg.sv
logic/bk_io_top.sv
tb/bk_io_sva.sv
tb/bk_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f verilog.f --top-module bk_io_tb -Mdir obj_dir

sim_out="$(./obj_dir/Vbk_io_tb 2>&1 || true)"
echo "$sim_out"

if grep -qxF "Done: no errors" <<< "$sim_out"; then
	exit 0
fi
exit 1
